//--- vga_pkg.sv
package vga_pkg;

    // display modes as seen by software in the status register
    typedef enum logic [2:0] {
        mode_off          = 3'd0,
        mode_text_40      = 3'd1,
        mode_graphics_640 = 3'd2,
        mode_graphics_320 = 3'd3,
        mode_text_80      = 3'd4
    } vga_mode_e;

    // register map of the bus port
    typedef enum logic [1:0] {
        reg_ram_base  = 2'd0,
        reg_font_base = 2'd1,
        reg_palette   = 2'd2,
        reg_status    = 2'd3
    } vga_reg_e;

    // horizontal timing in pixel clocks
    localparam logic [9:0] h_visible = 10'd640;
    localparam logic [9:0] h_front   = 10'd16;
    localparam logic [9:0] h_sync    = 10'd96;
    localparam logic [9:0] h_back    = 10'd48;
    localparam logic [9:0] h_total   = h_visible + h_front + h_sync + h_back;

    // vertical timing in lines
    localparam logic [9:0] v_visible = 10'd480;
    localparam logic [9:0] v_front   = 10'd10;
    localparam logic [9:0] v_sync    = 10'd2;
    localparam logic [9:0] v_back    = 10'd33;
    localparam logic [9:0] v_total   = v_visible + v_front + v_sync + v_back;

    // external RAM is addressed in 16-bit words
    localparam int ram_adr_w = 18;
    localparam logic [ram_adr_w-1:0] ram_base_default  = 18'd65536;
    localparam logic [ram_adr_w-1:0] font_base_default = 18'd131072;

    // words per displayed line in each graphics mode
    localparam logic [ram_adr_w-1:0] line_words_640 = 18'd320;
    localparam logic [ram_adr_w-1:0] line_words_320 = 18'd160;

    // scan position to RGB output, in cycles
    localparam int pipe_delay = 2;

endpackage

//--- vga_timing_if.sv
`timescale 1ns/1ps

interface vga_timing_if;

    // current scan position
    logic [9:0] col;
    logic [9:0] row;

    // high inside the 640x480 active area
    logic       visible;

    // one cycle at column 0 of every line
    logic       line_start;

    modport source (
        output col, row, visible, line_start
    );

    modport sink (
        input col, row, visible, line_start
    );

endinterface

//--- vga_regs.sv
`timescale 1ns/1ps

module vga_regs (
    input  logic                          I_wb_clk,
    input  logic                          I_reset,
    input  vga_pkg::vga_reg_e             wb_adr,
    input  logic [3:0]                    wb_sel,
    input  logic [31:0]                   wb_dat_in,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic                          pal_ack,
    vga_timing_if.sink                    timing,
    output logic                          wb_ack,
    output logic [31:0]                   wb_dat_out,
    output vga_pkg::vga_mode_e            mode,
    output logic [vga_pkg::ram_adr_w-1:0] ram_base,
    output logic                          pal_req,
    output logic [31:0]                   pal_word
);

    logic [vga_pkg::ram_adr_w-1:0] font_base;
    logic [31:0]                   status_word;
    logic                          wr_cycle;
    logic                          rd_cycle;

    assign wr_cycle = wb_stb && wb_we;
    assign rd_cycle = wb_stb && !wb_we;

    // row in the low half, visible flag at bit 16, mode at 26..24
    assign status_word = {5'b0, mode, 7'b0, timing.visible, 6'b0, timing.row};

    // single-cycle acknowledge, no wait states
    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_stb;
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            mode      <= vga_pkg::mode_off;
            ram_base  <= vga_pkg::ram_base_default;
            font_base <= vga_pkg::font_base_default;
            pal_req   <= 1'b0;
        end else if (wr_cycle) begin
            case (wb_adr)
                // bus carries byte addresses, keep the word part
                vga_pkg::reg_ram_base: begin
                    ram_base <= wb_dat_in[vga_pkg::ram_adr_w:1];
                end
                vga_pkg::reg_font_base: begin
                    font_base <= wb_dat_in[vga_pkg::ram_adr_w:1];
                end
                // flip the request so it differs from the palette's ack
                vga_pkg::reg_palette: begin
                    pal_req <= ~pal_ack;
                end
                // row and visible are read only, only the top byte is writable
                vga_pkg::reg_status: begin
                    if (wb_sel[3]) begin
                        mode <= vga_pkg::vga_mode_e'(wb_dat_in[26:24]);
                    end
                end
            endcase
        end
    end

    // palette entry word, held until the palette has taken it
    always_ff @(posedge I_wb_clk) begin
        if (wr_cycle && wb_adr == vga_pkg::reg_palette) begin
            pal_word <= wb_dat_in;
        end
    end

    // read data is ready together with the acknowledge
    always_ff @(posedge I_wb_clk) begin
        if (rd_cycle) begin
            case (wb_adr)
                vga_pkg::reg_ram_base: begin
                    wb_dat_out <= {{(31 - vga_pkg::ram_adr_w){1'b0}}, ram_base, 1'b0};
                end
                vga_pkg::reg_font_base: begin
                    wb_dat_out <= {{(31 - vga_pkg::ram_adr_w){1'b0}}, font_base, 1'b0};
                end
                vga_pkg::reg_palette: begin
                    wb_dat_out <= pal_word;
                end
                vga_pkg::reg_status: begin
                    wb_dat_out <= status_word;
                end
            endcase
        end
    end

    a_ack_follows_stb: assert property (
        @(posedge I_wb_clk) disable iff (I_reset)
        !$past(I_reset) |-> (wb_ack == $past(wb_stb))
    );

endmodule

//--- vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic         I_wb_clk,
    input  logic         I_reset,
    vga_timing_if.source timing,
    output logic         hsync,
    output logic         vsync
);

    logic [9:0]                    col;
    logic [9:0]                    row;
    logic                          hsync_raw;
    logic                          vsync_raw;
    logic [vga_pkg::pipe_delay-1:0] hsync_pipe;
    logic [vga_pkg::pipe_delay-1:0] vsync_pipe;

    // free-running scan counters
    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            col <= 10'd0;
            row <= 10'd0;
        end else if (col == vga_pkg::h_total - 10'd1) begin
            col <= 10'd0;
            if (row == vga_pkg::v_total - 10'd1) begin
                row <= 10'd0;
            end else begin
                row <= row + 10'd1;
            end
        end else begin
            col <= col + 10'd1;
        end
    end

    // both syncs are active low, starting after the front porch
    assign hsync_raw = !((col >= vga_pkg::h_visible + vga_pkg::h_front) &&
                         (col <  vga_pkg::h_visible + vga_pkg::h_front + vga_pkg::h_sync));
    assign vsync_raw = !((row >= vga_pkg::v_visible + vga_pkg::v_front) &&
                         (row <  vga_pkg::v_visible + vga_pkg::v_front + vga_pkg::v_sync));

    // delay the syncs to match the fetch and palette stages
    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            hsync_pipe <= '1;
            vsync_pipe <= '1;
        end else begin
            hsync_pipe <= {hsync_pipe[vga_pkg::pipe_delay-2:0], hsync_raw};
            vsync_pipe <= {vsync_pipe[vga_pkg::pipe_delay-2:0], vsync_raw};
        end
    end

    assign hsync = hsync_pipe[vga_pkg::pipe_delay-1];
    assign vsync = vsync_pipe[vga_pkg::pipe_delay-1];

    assign timing.col        = col;
    assign timing.row        = row;
    assign timing.visible    = (col < vga_pkg::h_visible) && (row < vga_pkg::v_visible);
    assign timing.line_start = (col == 10'd0);

endmodule

//--- vga_fetch.sv
`timescale 1ns/1ps

module vga_fetch (
    input  logic                          I_wb_clk,
    input  logic                          I_reset,
    vga_timing_if.sink                    timing,
    input  vga_pkg::vga_mode_e            mode,
    input  logic [vga_pkg::ram_adr_w-1:0] ram_base,
    input  logic [15:0]                   ram_dat,
    output logic [vga_pkg::ram_adr_w-1:0] ram_adr,
    output logic                          ram_req,
    output logic [7:0]                    pix_index,
    output logic                          pix_valid
);

    logic                          is_640;
    logic                          is_320;
    logic                          advance;
    logic [vga_pkg::ram_adr_w-1:0] line_base;
    logic [vga_pkg::ram_adr_w-1:0] next_base;
    logic [vga_pkg::ram_adr_w-1:0] cur_base;
    logic [vga_pkg::ram_adr_w-1:0] col_offset;
    logic                          byte_hi;
    logic                          byte_hi_d;
    logic                          req_d;
    logic [15:0]                   word_q;

    assign is_640 = (mode == vga_pkg::mode_graphics_640);
    assign is_320 = (mode == vga_pkg::mode_graphics_320);

    // in 320 mode a new line of words starts only on even rows
    assign advance   = is_320 ? !timing.row[0] : 1'b1;
    assign next_base = (timing.row == 10'd0) ? ram_base :
                       advance ? line_base + (is_320 ? vga_pkg::line_words_320
                                                     : vga_pkg::line_words_640)
                               : line_base;

    // at column 0 the stored base still belongs to the previous line
    assign cur_base   = timing.line_start ? next_base : line_base;
    assign col_offset = is_320 ? {10'd0, timing.col[9:2]} : {9'd0, timing.col[9:1]};
    assign ram_adr    = cur_base + col_offset;

    assign ram_req = timing.visible &&
                     ((is_640 && !timing.col[0]) || (is_320 && timing.col[1:0] == 2'b00));
    assign byte_hi = is_320 ? timing.col[1] : timing.col[0];

    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            line_base <= '0;
            req_d     <= 1'b0;
            byte_hi_d <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            if (timing.line_start) begin
                line_base <= next_base;
            end
            req_d     <= ram_req;
            byte_hi_d <= byte_hi;
            pix_valid <= timing.visible && (is_640 || is_320);
        end
    end

    // keep the returned word for the pixels after the first
    always_ff @(posedge I_wb_clk) begin
        if (req_d) begin
            word_q <= ram_dat;
        end
    end

    // first pixel of a word comes straight off the RAM bus
    assign pix_index = req_d     ? ram_dat[7:0] :
                       byte_hi_d ? word_q[15:8] : word_q[7:0];

    a_req_in_visible: assert property (
        @(posedge I_wb_clk) disable iff (I_reset)
        ram_req |-> (timing.col < vga_pkg::h_visible) && (timing.row < vga_pkg::v_visible)
    );

endmodule

//--- vga_palette.sv
`timescale 1ns/1ps

module vga_palette (
    input  logic        I_wb_clk,
    input  logic        I_reset,
    input  logic        pal_req,
    input  logic [31:0] pal_word,
    input  logic [7:0]  pix_index,
    input  logic        pix_valid,
    output logic        pal_ack,
    output logic [23:0] rgb
);

    logic [23:0] pal_mem [256];
    logic [7:0]  clr_cnt;
    logic        clearing;
    logic        pend;
    logic        wr_en;
    logic [7:0]  wr_idx;
    logic [23:0] wr_rgb;

    // an update waits until the clear sweep has finished
    assign pend   = (pal_req != pal_ack) && !clearing;
    assign wr_en  = clearing || pend;
    assign wr_idx = clearing ? clr_cnt : pal_word[31:24];
    assign wr_rgb = clearing ? 24'h0 : pal_word[23:0];

    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            clearing <= 1'b1;
            clr_cnt  <= 8'd0;
            pal_ack  <= 1'b0;
        end else begin
            if (clearing) begin
                clr_cnt <= clr_cnt + 8'd1;
                if (clr_cnt == 8'hff) begin
                    clearing <= 1'b0;
                end
            end
            if (pend) begin
                pal_ack <= pal_req;
            end
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (wr_en) begin
            pal_mem[wr_idx] <= wr_rgb;
        end
    end

    // black outside the active area and in the blank modes
    always_ff @(posedge I_wb_clk) begin
        if (I_reset) begin
            rgb <= 24'h0;
        end else begin
            rgb <= pix_valid ? pal_mem[pix_index] : 24'h0;
        end
    end

    a_ack_after_req: assert property (
        @(posedge I_wb_clk) disable iff (I_reset)
        $changed(pal_ack) |-> $past(pal_req != pal_ack)
    );

endmodule

//--- vga_wb32_extram.sv
`timescale 1ns/1ps

module vga_wb32_extram (
    input  logic        I_wb_clk,
    input  logic        I_reset,
    input  logic [1:0]  I_wb_adr,
    input  logic [3:0]  I_wb_sel,
    input  logic [31:0] I_wb_dat,
    input  logic        I_wb_stb,
    input  logic        I_wb_we,
    input  logic [15:0] I_ram_dat,
    output logic        O_wb_ack,
    output logic [31:0] O_wb_dat,
    output logic [17:0] O_ram_adr,
    output logic        O_ram_req,
    output logic        O_vga_hsync,
    output logic        O_vga_vsync,
    output logic [7:0]  O_vga_r,
    output logic [7:0]  O_vga_g,
    output logic [7:0]  O_vga_b
);

    vga_pkg::vga_mode_e            mode;
    logic [vga_pkg::ram_adr_w-1:0] ram_base;
    logic                          pal_req;
    logic                          pal_ack;
    logic [31:0]                   pal_word;
    logic [7:0]                    pix_index;
    logic                          pix_valid;
    logic [23:0]                   rgb;

    vga_timing_if timing_bus ();

    vga_regs regs_i (
        .I_wb_clk   (I_wb_clk),
        .I_reset    (I_reset),
        .wb_adr     (vga_pkg::vga_reg_e'(I_wb_adr)),
        .wb_sel     (I_wb_sel),
        .wb_dat_in  (I_wb_dat),
        .wb_stb     (I_wb_stb),
        .wb_we      (I_wb_we),
        .pal_ack    (pal_ack),
        .timing     (timing_bus.sink),
        .wb_ack     (O_wb_ack),
        .wb_dat_out (O_wb_dat),
        .mode       (mode),
        .ram_base   (ram_base),
        .pal_req    (pal_req),
        .pal_word   (pal_word)
    );

    vga_timing timing_i (
        .I_wb_clk (I_wb_clk),
        .I_reset  (I_reset),
        .timing   (timing_bus.source),
        .hsync    (O_vga_hsync),
        .vsync    (O_vga_vsync)
    );

    vga_fetch fetch_i (
        .I_wb_clk  (I_wb_clk),
        .I_reset   (I_reset),
        .timing    (timing_bus.sink),
        .mode      (mode),
        .ram_base  (ram_base),
        .ram_dat   (I_ram_dat),
        .ram_adr   (O_ram_adr),
        .ram_req   (O_ram_req),
        .pix_index (pix_index),
        .pix_valid (pix_valid)
    );

    vga_palette palette_i (
        .I_wb_clk  (I_wb_clk),
        .I_reset   (I_reset),
        .pal_req   (pal_req),
        .pal_word  (pal_word),
        .pix_index (pix_index),
        .pix_valid (pix_valid),
        .pal_ack   (pal_ack),
        .rgb       (rgb)
    );

    assign O_vga_r = rgb[23:16];
    assign O_vga_g = rgb[15:8];
    assign O_vga_b = rgb[7:0];

endmodule

//--- tb_vga_checks.svh
`ifndef TB_VGA_CHECKS_SVH
`define TB_VGA_CHECKS_SVH

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("ERR %s: got %h expected %h", name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_adr(input string name, input logic [17:0] got, input logic [17:0] exp);
    if (got !== exp) begin
        $display("ERR %s: got %h expected %h", name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_rgb(input string name, input logic [23:0] got, input logic [23:0] exp);
    if (got !== exp) begin
        $display("ERR %s: got %h expected %h", name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_mode(input string name, input vga_pkg::vga_mode_e got,
                          input vga_pkg::vga_mode_e exp);
    if (got !== exp) begin
        $display("ERR %s: got %h expected %h", name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERR %s: got %h expected %h", name, got, exp);
        stop_on_error();
    end
endtask

// the acknowledge comes one cycle after the strobe
task automatic await_ack();
    int n;
    n = 0;
    @(posedge I_wb_clk);
    #10;
    while (!O_wb_ack) begin
        if (n == 16) begin
            $display("the bus port never acknowledged the strobe");
            stop_on_error();
        end
        n++;
        @(posedge I_wb_clk);
        #10;
    end
endtask

// returns in the cycle after the scan counters stood at row, col
task automatic wait_scan_pos(input int row, input int col);
    int n;
    int limit;
    n = 0;
    limit = int'(vga_pkg::h_total) * int'(vga_pkg::v_total) + 8;
    @(posedge I_wb_clk);
    #10;
    while (!(srow == row && scol == col)) begin
        if (n > limit) begin
            $display("scan position %0d,%0d was not reached within a frame", row, col);
            stop_on_error();
        end
        n++;
        @(posedge I_wb_clk);
        #10;
    end
endtask

`endif

//--- tb_vga_wb32_extram.sv
`timescale 1ns/1ps

module tb_vga_wb32_extram;

    logic        I_wb_clk;
    logic        I_reset;
    logic [1:0]  I_wb_adr;
    logic [3:0]  I_wb_sel;
    logic [31:0] I_wb_dat;
    logic        I_wb_stb;
    logic        I_wb_we;
    logic [15:0] I_ram_dat;
    logic        O_wb_ack;
    logic [31:0] O_wb_dat;
    logic [17:0] O_ram_adr;
    logic        O_ram_req;
    logic        O_vga_hsync;
    logic        O_vga_vsync;
    logic [7:0]  O_vga_r;
    logic [7:0]  O_vga_g;
    logic [7:0]  O_vga_b;

    vga_pkg::vga_mode_e            cur_mode;
    logic [vga_pkg::ram_adr_w-1:0] cur_base;
    logic [23:0]                   pal_copy [256];
    logic [31:0]                   pattern;
    integer                        seed;
    int                            scol;
    int                            srow;
    int                            ocol;
    int                            orow;
    int                            cyc;
    int                            last_fall;
    logic                          have_fall;
    logic                          hs_prev;
    logic                          check_on;
    logic                          req_s;
    logic [17:0]                   adr_s;
    logic                          stb_s;

    vga_wb32_extram dut_i (
        .I_wb_clk    (I_wb_clk),
        .I_reset     (I_reset),
        .I_wb_adr    (I_wb_adr),
        .I_wb_sel    (I_wb_sel),
        .I_wb_dat    (I_wb_dat),
        .I_wb_stb    (I_wb_stb),
        .I_wb_we     (I_wb_we),
        .I_ram_dat   (I_ram_dat),
        .O_wb_ack    (O_wb_ack),
        .O_wb_dat    (O_wb_dat),
        .O_ram_adr   (O_ram_adr),
        .O_ram_req   (O_ram_req),
        .O_vga_hsync (O_vga_hsync),
        .O_vga_vsync (O_vga_vsync),
        .O_vga_r     (O_vga_r),
        .O_vga_g     (O_vga_g),
        .O_vga_b     (O_vga_b)
    );

    always #50 I_wb_clk = ~I_wb_clk;

    task automatic stop_on_error();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    `include "tb_vga_checks.svh"

    // every word depends on all address bits
    function automatic logic [15:0] ram_word(input logic [17:0] adr);
        return pattern[15:0] ^ adr[15:0] ^ {14'd0, adr[17:16]};
    endfunction

    function automatic logic in_view(input int col, input int row);
        return col < vga_pkg::h_visible && row < vga_pkg::v_visible;
    endfunction

    function automatic logic exp_req(input int col, input int row);
        if (!in_view(col, row)) return 1'b0;
        if (cur_mode == vga_pkg::mode_graphics_640) return col % 2 == 0;
        if (cur_mode == vga_pkg::mode_graphics_320) return col % 4 == 0;
        return 1'b0;
    endfunction

    function automatic logic [17:0] exp_adr(input int col, input int row);
        if (cur_mode == vga_pkg::mode_graphics_320) begin
            return cur_base + 18'((row / 2) * 160 + col / 4);
        end
        return cur_base + 18'(row * 320 + col / 2);
    endfunction

    // palette colour of the byte the RAM model returns for this pixel
    function automatic logic [23:0] exp_rgb(input int col, input int row);
        logic [15:0] w;
        logic        hi;
        if (!exp_req(col - col % 4, row)) return 24'h0;
        w  = ram_word(exp_adr(col, row));
        hi = (cur_mode == vga_pkg::mode_graphics_320) ? col[1] : col[0];
        return pal_copy[hi ? w[15:8] : w[7:0]];
    endfunction

    function automatic logic [31:0] exp_status(input int col, input int row);
        return {5'd0, cur_mode, 7'd0, in_view(col, row), 16'(row)};
    endfunction

    task automatic step_scan(inout int col, inout int row);
        col = col + 1;
        if (col == vga_pkg::h_total) begin
            col = 0;
            row = (row + 1 == vga_pkg::v_total) ? 0 : row + 1;
        end
    endtask

    task automatic bus_write(input vga_pkg::vga_reg_e adr, input logic [3:0] sel,
                             input logic [31:0] dat);
        @(posedge I_wb_clk);
        #10;
        I_wb_adr = adr;
        I_wb_sel = sel;
        I_wb_dat = dat;
        I_wb_we  = 1'b1;
        I_wb_stb = 1'b1;
        await_ack();
        I_wb_stb = 1'b0;
        I_wb_we  = 1'b0;
    endtask

    task automatic bus_read(input vga_pkg::vga_reg_e adr, output logic [31:0] dat);
        @(posedge I_wb_clk);
        #10;
        I_wb_adr = adr;
        I_wb_sel = 4'hf;
        I_wb_we  = 1'b0;
        I_wb_stb = 1'b1;
        await_ack();
        dat      = O_wb_dat;
        I_wb_stb = 1'b0;
    endtask

    // tracks scan and output positions and checks ack, syncs, requests and colour
    always @(negedge I_wb_clk) begin
        if (I_reset) begin
            scol      = int'(vga_pkg::h_total) - 1;
            srow      = int'(vga_pkg::v_total) - 1;
            ocol      = int'(vga_pkg::h_total) - 1 - vga_pkg::pipe_delay;
            orow      = int'(vga_pkg::v_total) - 1;
            have_fall = 1'b0;
            hs_prev   = 1'b1;
        end else begin
            step_scan(scol, srow);
            step_scan(ocol, orow);
            cyc++;
            // the acknowledge is the strobe of the previous cycle
            check_flag("O_wb_ack", O_wb_ack, stb_s);
            check_flag("O_vga_hsync", O_vga_hsync,
                       !(ocol >= vga_pkg::h_visible + vga_pkg::h_front &&
                         ocol < vga_pkg::h_visible + vga_pkg::h_front + vga_pkg::h_sync));
            check_flag("O_vga_vsync", O_vga_vsync,
                       !(orow >= vga_pkg::v_visible + vga_pkg::v_front &&
                         orow < vga_pkg::v_visible + vga_pkg::v_front + vga_pkg::v_sync));
            if (hs_prev && !O_vga_hsync) begin
                if (have_fall) check_word("hsync period", cyc - last_fall, vga_pkg::h_total);
                last_fall = cyc;
                have_fall = 1'b1;
            end
            if (!hs_prev && O_vga_hsync) begin
                check_word("hsync low time", cyc - last_fall, vga_pkg::h_sync);
            end
            hs_prev = O_vga_hsync;
            if (check_on) begin
                check_flag("O_ram_req", O_ram_req, exp_req(scol, srow));
                if (O_ram_req) check_adr("O_ram_adr", O_ram_adr, exp_adr(scol, srow));
                check_rgb("O_vga_rgb", {O_vga_r, O_vga_g, O_vga_b}, exp_rgb(ocol, orow));
            end
        end
        req_s = O_ram_req;
        adr_s = O_ram_adr;
        stb_s = I_wb_stb;
    end

    // external RAM with one cycle of read latency
    always @(posedge I_wb_clk) begin
        #10;
        I_ram_dat = req_s ? ram_word(adr_s) : 16'hxxxx;
    end

    initial begin
        logic [31:0] d;
        logic [31:0] pal_last;
        logic [15:0] w;
        I_wb_clk  = 1'b0;
        I_reset   = 1'b1;
        I_wb_adr  = 2'd0;
        I_wb_sel  = 4'h0;
        I_wb_dat  = 32'h0;
        I_wb_stb  = 1'b0;
        I_wb_we   = 1'b0;
        I_ram_dat = 16'h0;
        seed      = 32'h3b45_5f99;
        pattern   = $random(seed);
        check_on  = 1'b0;
        req_s     = 1'b0;
        stb_s     = 1'b0;
        cyc       = 0;
        cur_mode  = vga_pkg::mode_off;
        cur_base  = vga_pkg::ram_base_default;
        for (int i = 0; i < 256; i++) pal_copy[i] = 24'h0;
        repeat (4) @(posedge I_wb_clk);
        #10;
        I_reset  = 1'b0;
        check_on = 1'b1;

        // defaults after reset, then a whole blank line
        bus_read(vga_pkg::reg_status, d);
        check_mode("status mode", vga_pkg::vga_mode_e'(d[26:24]), vga_pkg::mode_off);
        check_word("status", d, exp_status(scol, srow));
        bus_read(vga_pkg::reg_ram_base, d);
        check_word("ram base", d, {13'd0, vga_pkg::ram_base_default, 1'b0});
        bus_read(vga_pkg::reg_font_base, d);
        check_word("font base", d, {13'd0, vga_pkg::font_base_default, 1'b0});
        wait_scan_pos(2, 0);

        // register readback, text mode displays like mode_off
        bus_write(vga_pkg::reg_ram_base, 4'hf, 32'h0002_4680);
        bus_read(vga_pkg::reg_ram_base, d);
        check_word("ram base", d, 32'h0002_4680 & 32'h0007_fffe);
        cur_base = 18'h12340;
        bus_write(vga_pkg::reg_font_base, 4'hf, 32'h0013_5797);
        bus_read(vga_pkg::reg_font_base, d);
        check_word("font base", d, 32'h0013_5797 & 32'h0007_fffe);
        for (int k = 0; k < 8; k++) begin
            w        = ram_word(cur_base + 18'(k));
            pal_last = {w[7:0], 24'($random(seed))};
            pal_copy[pal_last[31:24]] = pal_last[23:0];
            bus_write(vga_pkg::reg_palette, 4'hf, pal_last);
        end
        bus_read(vga_pkg::reg_palette, d);
        check_word("palette word", d, pal_last);
        bus_write(vga_pkg::reg_status, 4'h8, {5'd0, vga_pkg::mode_text_80, 24'd0});
        cur_mode = vga_pkg::mode_text_80;
        bus_write(vga_pkg::reg_status, 4'h7, {5'd0, vga_pkg::mode_graphics_640, 24'hff_ffff});
        bus_read(vga_pkg::reg_status, d);
        check_mode("status mode", vga_pkg::vga_mode_e'(d[26:24]), vga_pkg::mode_text_80);

        // 640 mode from the top of a fresh frame
        check_on = 1'b0;
        bus_write(vga_pkg::reg_status, 4'h8, {5'd0, vga_pkg::mode_graphics_640, 24'd0});
        cur_mode = vga_pkg::mode_graphics_640;
        wait_scan_pos(int'(vga_pkg::v_total) - 1, int'(vga_pkg::h_total) - 1);
        check_on = 1'b1;
        wait_scan_pos(3, 200);
        bus_read(vga_pkg::reg_status, d);
        check_word("status", d, exp_status(scol, srow));
        wait_scan_pos(4, 0);

        // 320 mode with a new base
        check_on = 1'b0;
        bus_write(vga_pkg::reg_ram_base, 4'hf, 32'h0000_0a00);
        cur_base = 18'h00500;
        bus_write(vga_pkg::reg_status, 4'h8, {5'd0, vga_pkg::mode_graphics_320, 24'd0});
        cur_mode = vga_pkg::mode_graphics_320;
        wait_scan_pos(int'(vga_pkg::v_total) - 1, int'(vga_pkg::h_total) - 1);
        check_on = 1'b1;
        wait_scan_pos(4, 0);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- list.f
+incdir+.
vga_pkg.sv
vga_timing_if.sv
vga_regs.sv
vga_timing.sv
vga_fetch.sv
vga_palette.sv
vga_wb32_extram.sv
tb_vga_wb32_extram.sv
